//--- filelist.f
isa_pkg.sv
fetch_pkg.sv
lane_select.sv
lane_predecode.sv
return_stack.sv
pc_ctrl_super.sv
fetch_front.sv
fetch_front_asserts.sv
tb_fetch_front.sv

//--- Makefile
# Verilator build and run of the fetch front end testbench

VERILATOR ?= verilator
TOP       ?= tb_fetch_front
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run $(TOP), judge the run from $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "STATUS: PASS" $(LOG); then echo "No pass line in $(LOG)"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb_fetch_front.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_front;

	localparam int          CLK_PERIOD   = 100;
	localparam int          DRIVE_DELAY  = 1;
	localparam int          RESET_CYCLES = 8;
	localparam int          MARGIN       = 20;
	localparam int unsigned SEED         = 32'h6bfa;

	// Filler words use OP-IMM so they never redirect
	localparam isa_pkg::opcode_t OP_IMM = 7'b0010011;
	localparam isa_pkg::word_t   FILL   = '0;

	typedef struct packed {
		logic                     parallel_mode;
		logic                     buble;
		logic                     misprediction;
		isa_pkg::word_t           correct_pc;
		fetch_pkg::instr_bundle_t instr;
		isa_pkg::word_t           exp_pc;
	} row_t;

	logic                     clk;
	logic                     reset;
	logic                     parallel_mode;
	logic                     buble;
	logic                     misprediction;
	isa_pkg::word_t           correct_pc;
	fetch_pkg::instr_bundle_t instr;
	fetch_pkg::addr_bundle_t  lanes;

	row_t           rows[$];
	isa_pkg::word_t model_pc;
	isa_pkg::word_t model_ras[$];
	int unsigned    cycles = 0;
	int unsigned    cycle_limit;

	fetch_front uut (
		.clk           (clk),
		.reset         (reset),
		.parallel_mode (parallel_mode),
		.buble         (buble),
		.misprediction (misprediction),
		.correct_pc    (correct_pc),
		.instr         (instr),
		.lanes         (lanes)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			stop_on_error($sformatf("Timeout after %0d clock cycles", cycles));
		end
	end

	task automatic stop_on_error(string line);
		$display("%s", line);
		$display("STATUS: FAIL");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_word(string name, isa_pkg::word_t got, isa_pkg::word_t exp);
		if (got !== exp) begin
			stop_on_error($sformatf("FAIL %s: got %h, expected %h", name, got, exp));
		end
	endtask

	task automatic check_lane(string name, fetch_pkg::lane_addr_t got,
			fetch_pkg::lane_addr_t exp);
		if (got !== exp) begin
			stop_on_error($sformatf("FAIL %s: got %h/%h/%h, expected %h/%h/%h", name,
				got.inst_addr, got.current_pc, got.pc_save,
				exp.inst_addr, exp.current_pc, exp.pc_save));
		end
	endtask

	//////////////////////////////////////////////////
	// Instruction encoders

	function automatic isa_pkg::word_t jal_word(isa_pkg::reg_t rd, logic [20:0] off);
		return {off[20], off[10:1], off[11], off[19:12], rd, isa_pkg::OP_JAL};
	endfunction

	function automatic isa_pkg::word_t jalr_word(isa_pkg::reg_t rd, isa_pkg::reg_t rs1,
			logic [11:0] off);
		return {off, rs1, 3'b000, rd, isa_pkg::OP_JALR};
	endfunction

	function automatic isa_pkg::word_t auipc_word(isa_pkg::reg_t rd, logic [19:0] upper);
		return {upper, rd, isa_pkg::OP_AUIPC};
	endfunction

	function automatic isa_pkg::word_t fill_word();
		isa_pkg::word_t bits;
		bits = $urandom();
		return {bits[31:7], OP_IMM};
	endfunction

	//////////////////////////////////////////////////
	// Reference model

	function automatic fetch_pkg::lane_ctl_t decode_word(isa_pkg::word_t w);
		fetch_pkg::lane_ctl_t c;
		logic                 rd_link;
		logic                 rs1_link;
		c        = '0;
		rd_link  = w[11:7] inside {isa_pkg::LINK_RA, isa_pkg::LINK_ALT};
		rs1_link = w[19:15] inside {isa_pkg::LINK_RA, isa_pkg::LINK_ALT};
		case (w[6:0])
			isa_pkg::OP_JAL: begin
				c.jump = 1'b1;
				c.imm  = isa_pkg::word_t'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
			end
			isa_pkg::OP_JALR: begin
				c.jalr = 1'b1;
				c.imm  = isa_pkg::word_t'($signed(w[31:20]));
			end
			isa_pkg::OP_AUIPC: c.imm = {w[31:12], 12'h000};
			default: c.imm = '0;
		endcase
		c.link_push = (c.jump || c.jalr) && rd_link;
		c.link_pop  = c.jalr && rs1_link && !rd_link;
		return c;
	endfunction

	task automatic run_model(row_t r, output fetch_pkg::addr_bundle_t exp_lanes);
		fetch_pkg::lane_ctl_t ctl [fetch_pkg::LANES];
		isa_pkg::word_t       lane_pc [fetch_pkg::LANES];
		isa_pkg::word_t       target;
		isa_pkg::word_t       next_pc;
		int                   dec;
		dec = -1;
		for (int k = 0; k < fetch_pkg::LANES; k++) begin
			ctl[k]     = decode_word(r.instr[k]);
			lane_pc[k] = r.parallel_mode ? model_pc + 32'(4 * k) : model_pc;
			if (dec < 0 && (ctl[k].jump || ctl[k].jalr)) begin
				dec = k;
			end
		end
		if (dec < 0) begin
			target = model_pc + (r.parallel_mode ? 32'd20 : 32'd4);
		end else if (ctl[dec].jump) begin
			target = (lane_pc[dec] + ctl[dec].imm) & ~32'h3;
		end else if (ctl[dec].link_pop && model_ras.size() > 0) begin
			target = model_ras[0];
		end else begin
			target = lane_pc[dec] + 32'd4;
		end
		if (r.misprediction) begin
			next_pc = r.correct_pc;
		end else if (r.buble) begin
			next_pc = model_pc;
		end else begin
			next_pc = target;
		end
		for (int k = 0; k < fetch_pkg::LANES; k++) begin
			exp_lanes[k].current_pc = lane_pc[k];
			exp_lanes[k].inst_addr  = r.parallel_mode ? next_pc + 32'(4 * k) : next_pc;
			if (ctl[k].jump || ctl[k].jalr) begin
				exp_lanes[k].pc_save = lane_pc[k] + 32'd4;
			end else begin
				exp_lanes[k].pc_save = lane_pc[k] + (ctl[k].imm & ~32'h3);
			end
		end
		// Stack moves only on a taken edge that is not flushed
		if (!r.buble && !r.misprediction && dec >= 0) begin
			if (ctl[dec].link_push) begin
				model_ras.push_front(lane_pc[dec] + 32'd4);
				if (model_ras.size() > fetch_pkg::RAS_DEPTH) begin
					void'(model_ras.pop_back());
				end
			end else if (ctl[dec].link_pop && model_ras.size() > 0) begin
				void'(model_ras.pop_front());
			end
		end
		model_pc = next_pc;
	endtask

	//////////////////////////////////////////////////
	// Stimulus table

	task automatic add_row(logic pm, logic bub, logic mis, isa_pkg::word_t cpc,
			int lane, isa_pkg::word_t word, isa_pkg::word_t exp_pc);
		row_t r;
		r.parallel_mode = pm;
		r.buble         = bub;
		r.misprediction = mis;
		r.correct_pc    = cpc;
		r.exp_pc        = exp_pc;
		for (int k = 0; k < fetch_pkg::LANES; k++) begin
			r.instr[k] = fill_word();
		end
		if (word != FILL) begin
			r.instr[lane] = word;
		end
		rows.push_back(r);
	endtask

	task automatic build_table();
		// Serial and parallel stepping
		add_row(1'b0, 1'b0, 1'b0, '0, 0, FILL, 32'h8000_0000);
		add_row(1'b0, 1'b0, 1'b0, '0, 0, FILL, 32'h8000_0004);
		add_row(1'b1, 1'b0, 1'b0, '0, 0, FILL, 32'h8000_0008);
		// AUIPC save value, then a JAL whose offset has bit 1 set
		add_row(1'b1, 1'b0, 1'b0, '0, 1, auipc_word(5'd10, 20'h12345), 32'h8000_001c);
		add_row(1'b1, 1'b0, 1'b0, '0, 2, jal_word(5'd0, 21'h102), 32'h8000_0030);
		// Call through x1 and its return
		add_row(1'b1, 1'b0, 1'b0, '0, 0, jal_word(5'd1, 21'h040), 32'h8000_0138);
		add_row(1'b1, 1'b0, 1'b0, '0, 3, jalr_word(5'd0, 5'd1, 12'h000), 32'h8000_0178);
		// Empty stack falls through
		add_row(1'b0, 1'b0, 1'b0, '0, 0, jalr_word(5'd0, 5'd1, 12'h000), 32'h8000_013c);
		// Bubbles hold the PC
		add_row(1'b0, 1'b1, 1'b0, '0, 0, FILL, 32'h8000_0140);
		add_row(1'b1, 1'b1, 1'b0, '0, 0, jal_word(5'd1, 21'h800), 32'h8000_0140);
		add_row(1'b1, 1'b1, 1'b1, 32'h8000_2000, 0, FILL, 32'h8000_0140);
		// Flushed call must not reach the stack
		add_row(1'b1, 1'b0, 1'b1, 32'h8000_4000, 0, jal_word(5'd1, 21'h080), 32'h8000_2000);
		add_row(1'b1, 1'b0, 1'b0, '0, 2, jalr_word(5'd0, 5'd1, 12'h010), 32'h8000_4000);
		// Call and return through x5
		add_row(1'b0, 1'b0, 1'b0, '0, 0, jal_word(5'd5, 21'h020), 32'h8000_400c);
		add_row(1'b1, 1'b0, 1'b0, '0, 4, jalr_word(5'd0, 5'd5, 12'h000), 32'h8000_402c);
		add_row(1'b0, 1'b0, 1'b0, '0, 0, FILL, 32'h8000_4010);
		add_row(1'b1, 1'b0, 1'b0, '0, 0, FILL, 32'h8000_4014);
	endtask

	initial begin
		row_t                    r;
		fetch_pkg::addr_bundle_t exp_lanes;
		clk           = 1'b0;
		reset         = 1'b0;
		parallel_mode = 1'b0;
		buble         = 1'b0;
		misprediction = 1'b0;
		correct_pc    = '0;
		instr         = '0;
		void'($urandom(SEED));
		build_table();
		cycle_limit = rows.size() + RESET_CYCLES + MARGIN;

		repeat (RESET_CYCLES - 1) @(posedge clk);
		@(negedge clk);
		check_word("lanes[0].inst_addr in reset", lanes[0].inst_addr, fetch_pkg::RESET_PC);
		@(posedge clk);
		#DRIVE_DELAY;
		reset    = 1'b1;
		model_pc = fetch_pkg::RESET_PC;

		for (int i = 0; i < rows.size(); i++) begin
			if (i != 0) begin
				@(posedge clk);
				#DRIVE_DELAY;
			end
			r             = rows[i];
			parallel_mode = r.parallel_mode;
			buble         = r.buble;
			misprediction = r.misprediction;
			correct_pc    = r.correct_pc;
			instr         = r.instr;
			// Outputs settle well before the falling edge
			@(negedge clk);
			run_model(r, exp_lanes);
			check_word("lanes[0].current_pc", lanes[0].current_pc, r.exp_pc);
			for (int k = 0; k < fetch_pkg::LANES; k++) begin
				check_lane($sformatf("lanes[%0d] inst_addr/current_pc/pc_save", k),
					lanes[k], exp_lanes[k]);
			end
		end

		$display("STATUS: PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- fetch_front_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_front_asserts (
	input logic                    clk,
	input logic                    reset,
	input logic                    parallel_mode,
	input fetch_pkg::addr_bundle_t lanes
);

	//////////////////////////////////////////////////
	// Per-lane address properties

	for (genvar k = 0; k < fetch_pkg::LANES; k++) begin : g_lane
		// Lane PCs stay word aligned
		a_aligned: assert property (@(posedge clk) disable iff (!reset)
			lanes[k].current_pc[1:0] == 2'b00)
			else $error("lane %0d current_pc %h is not word aligned", k, lanes[k].current_pc);

		// Serial mode repeats the lane 0 addresses
		if (k > 0) begin : g_serial
			a_serial: assert property (@(posedge clk) disable iff (!reset)
				!parallel_mode |-> (lanes[k].current_pc == lanes[0].current_pc &&
					lanes[k].inst_addr == lanes[0].inst_addr))
				else $error("lane %0d addresses differ from lane 0 in serial mode", k);
		end
	end

	// Fetch starts at the reset vector
	a_reset_addr: assert property (@(posedge clk)
		!reset |-> lanes[0].inst_addr == fetch_pkg::RESET_PC)
		else $error("lane 0 inst_addr %h is not the reset PC", lanes[0].inst_addr);

endmodule

bind fetch_front fetch_front_asserts u_asserts (
	.clk           (clk),
	.reset         (reset),
	.parallel_mode (parallel_mode),
	.lanes         (lanes)
);

`default_nettype wire

//--- fetch_front.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_front (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     parallel_mode,
	input  logic                     buble,
	input  logic                     misprediction,
	input  isa_pkg::word_t           correct_pc,
	input  fetch_pkg::instr_bundle_t instr,
	output fetch_pkg::addr_bundle_t  lanes
);

	fetch_pkg::ctl_bundle_t ctl;

	fetch_pkg::lane_ctl_t ras_req;
	isa_pkg::word_t       ras_push_addr;
	logic                 ras_advance;

	logic           prediction_valid;
	isa_pkg::word_t prediction_target;

	//////////////////////////////////////////////////
	// One pre-decoder per lane

	for (genvar k = 0; k < fetch_pkg::LANES; k++) begin : g_predecode
		lane_predecode u_predecode (
			.instr (instr[k]),
			.ctl   (ctl[k])
		);
	end

	//////////////////////////////////////////////////
	// Return address prediction

	return_stack u_ras (
		.clk               (clk),
		.reset             (reset),
		.advance           (ras_advance),
		.req               (ras_req),
		.push_addr         (ras_push_addr),
		.prediction_valid  (prediction_valid),
		.prediction_target (prediction_target)
	);

	//////////////////////////////////////////////////
	// PC register and lane addresses

	pc_ctrl_super u_pc_ctrl (
		.clk                    (clk),
		.reset                  (reset),
		.buble                  (buble),
		.parallel_mode          (parallel_mode),
		.misprediction          (misprediction),
		.correct_pc             (correct_pc),
		.ctl                    (ctl),
		.jalr_prediction_valid  (prediction_valid),
		.jalr_prediction_target (prediction_target),
		.lanes                  (lanes),
		.ras_req                (ras_req),
		.ras_push_addr          (ras_push_addr),
		.ras_advance            (ras_advance)
	);

endmodule

`default_nettype wire

//--- pc_ctrl_super.sv
`timescale 1ns/1ps
`default_nettype none

module pc_ctrl_super (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    buble,
	input  logic                    parallel_mode,
	input  logic                    misprediction,
	input  isa_pkg::word_t          correct_pc,
	input  fetch_pkg::ctl_bundle_t  ctl,
	input  logic                    jalr_prediction_valid,
	input  isa_pkg::word_t          jalr_prediction_target,
	output fetch_pkg::addr_bundle_t lanes,
	output fetch_pkg::lane_ctl_t    ras_req,
	output isa_pkg::word_t          ras_push_addr,
	output logic                    ras_advance
);

	isa_pkg::word_t pc_q;
	isa_pkg::word_t pc_step;
	isa_pkg::word_t pc_plus;
	isa_pkg::word_t pc_next;
	isa_pkg::word_t inst_base;

	isa_pkg::word_t [fetch_pkg::LANES-1:0] lane_pc;
	logic [fetch_pkg::LANES-1:0]           redirect;

	fetch_pkg::lane_ctl_t dec_ctl;
	isa_pkg::word_t       dec_pc;
	isa_pkg::word_t       dec_pc_plus4;
	logic                 dec_hit;

	// Targets drop the two low bits to stay word aligned
	function automatic isa_pkg::word_t word_align(input isa_pkg::word_t value);
		return {value[31:2], 2'b00};
	endfunction

	//////////////////////////////////////////////////
	// Per-lane addresses

	for (genvar k = 0; k < fetch_pkg::LANES; k++) begin : g_lane
		assign redirect[k] = ctl[k].jump | ctl[k].jalr;

		// Lanes spread out by one word only in parallel mode
		assign lane_pc[k] = parallel_mode ? pc_q + k * fetch_pkg::INSTR_BYTES : pc_q;

		assign lanes[k].current_pc = lane_pc[k];
		assign lanes[k].inst_addr =
			parallel_mode ? inst_base + k * fetch_pkg::INSTR_BYTES : inst_base;

		// Jumps save the return address, auipc saves pc + imm
		assign lanes[k].pc_save = redirect[k] ? lane_pc[k] + fetch_pkg::INSTR_BYTES
			: lane_pc[k] + word_align(ctl[k].imm);
	end

	//////////////////////////////////////////////////
	// Deciding lane

	lane_select #(
		.payload_t(fetch_pkg::lane_ctl_t)
	) u_sel_ctl (
		.sel  (redirect),
		.data (ctl),
		.out  (dec_ctl),
		.hit  (dec_hit)
	);

	lane_select #(
		.payload_t(isa_pkg::word_t)
	) u_sel_pc (
		.sel  (redirect),
		.data (lane_pc),
		.out  (dec_pc),
		.hit  ()
	);

	assign dec_pc_plus4 = dec_pc + fetch_pkg::INSTR_BYTES;

	//////////////////////////////////////////////////
	// Next PC

	assign pc_step = parallel_mode ? fetch_pkg::BLOCK_BYTES : fetch_pkg::INSTR_BYTES;

	always_comb begin
		if (!dec_hit) begin
			pc_plus = pc_q + pc_step;
		end else if (dec_ctl.jump) begin
			pc_plus = dec_pc + word_align(dec_ctl.imm);
		end else if (jalr_prediction_valid) begin
			// A hit without jump is a jalr
			pc_plus = jalr_prediction_target;
		end else begin
			pc_plus = dec_pc_plus4;
		end
	end

	// Execute stage correction beats any prediction
	assign pc_next = misprediction ? correct_pc : pc_plus;

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			pc_q <= fetch_pkg::RESET_PC;
		end else if (!buble || misprediction) begin
			pc_q <= pc_next;
		end
	end

	// Fetch address runs one step ahead of the register
	always_comb begin
		if (!reset) begin
			inst_base = fetch_pkg::RESET_PC;
		end else if (buble && !misprediction) begin
			inst_base = pc_q;
		end else begin
			inst_base = pc_next;
		end
	end

	//////////////////////////////////////////////////
	// Return stack request

	assign ras_req       = dec_ctl;
	assign ras_push_addr = dec_pc_plus4;

	// Stack freezes on a bubble and ignores a flushed block
	assign ras_advance = !buble && !misprediction;

endmodule

`default_nettype wire

//--- return_stack.sv
`timescale 1ns/1ps
`default_nettype none

module return_stack (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 advance,
	input  fetch_pkg::lane_ctl_t req,
	input  isa_pkg::word_t       push_addr,
	output logic                 prediction_valid,
	output isa_pkg::word_t       prediction_target
);

	// Entry 0 is the top of the stack
	isa_pkg::word_t stack [fetch_pkg::RAS_DEPTH];

	fetch_pkg::ras_cnt_t count;

	logic not_empty;
	logic full;
	logic do_push;
	logic do_pop;

	assign not_empty = (count != '0);
	assign full      = (count == fetch_pkg::ras_cnt_t'(fetch_pkg::RAS_DEPTH));

	assign do_push = advance && req.link_push;
	assign do_pop  = advance && req.link_pop && not_empty;

	//////////////////////////////////////////////////
	// Occupancy

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			count <= '0;
		end else if (do_push) begin
			// Saturate when full, the oldest entry falls off the bottom
			if (!full) begin
				count <= count + 1'b1;
			end
		end else if (do_pop) begin
			count <= count - 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// Entry storage

	always_ff @(posedge clk) begin
		if (do_push) begin
			stack[0] <= push_addr;
			for (int i = 1; i < fetch_pkg::RAS_DEPTH; i++) begin
				stack[i] <= stack[i-1];
			end
		end else if (do_pop) begin
			for (int i = 0; i < fetch_pkg::RAS_DEPTH - 1; i++) begin
				stack[i] <= stack[i+1];
			end
		end
	end

	// Prediction is only offered to a return
	assign prediction_valid  = not_empty && req.link_pop;
	assign prediction_target = stack[0];

endmodule

`default_nettype wire

//--- lane_predecode.sv
`timescale 1ns/1ps
`default_nettype none

module lane_predecode (
	input  isa_pkg::word_t       instr,
	output fetch_pkg::lane_ctl_t ctl
);

	isa_pkg::opcode_t opcode;
	isa_pkg::reg_t    rd;
	isa_pkg::reg_t    rs1;

	logic is_jal;
	logic is_jalr;
	logic is_auipc;
	logic rd_link;
	logic rs1_link;

	isa_pkg::word_t imm_j;
	isa_pkg::word_t imm_i;
	isa_pkg::word_t imm_u;

	//////////////////////////////////////////////////
	// Field extraction

	assign opcode = instr[6:0];
	assign rd     = instr[11:7];
	assign rs1    = instr[19:15];

	assign is_jal   = (opcode == isa_pkg::OP_JAL);
	assign is_jalr  = (opcode == isa_pkg::OP_JALR);
	assign is_auipc = (opcode == isa_pkg::OP_AUIPC);

	// x1 and x5 both count as link registers
	assign rd_link  = (rd == isa_pkg::LINK_RA) || (rd == isa_pkg::LINK_ALT);
	assign rs1_link = (rs1 == isa_pkg::LINK_RA) || (rs1 == isa_pkg::LINK_ALT);

	//////////////////////////////////////////////////
	// Immediates, all sign extended

	// J-type scrambles bits 20..1 across the word
	assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

	assign imm_i = {{20{instr[31]}}, instr[31:20]};

	// U-type fills the upper 20 bits
	assign imm_u = {instr[31:12], 12'b0};

	//////////////////////////////////////////////////
	// Lane control

	always_comb begin
		ctl.jump = is_jal;
		ctl.jalr = is_jalr;

		// Call hint on any jump that writes a link register
		ctl.link_push = (is_jal || is_jalr) && rd_link;

		// Return hint only when it is not also a call
		ctl.link_pop = is_jalr && rs1_link && !rd_link;

		if (is_jal) begin
			ctl.imm = imm_j;
		end else if (is_jalr) begin
			ctl.imm = imm_i;
		end else if (is_auipc) begin
			ctl.imm = imm_u;
		end else begin
			ctl.imm = '0;
		end
	end

endmodule

`default_nettype wire

//--- lane_select.sv
`timescale 1ns/1ps
`default_nettype none

module lane_select #(
	parameter type payload_t = isa_pkg::word_t
) (
	input  logic [fetch_pkg::LANES-1:0]     sel,
	input  payload_t [fetch_pkg::LANES-1:0] data,
	output payload_t                        out,
	output logic                            hit
);

	// Lowest set bit wins, so walk from the top down
	always_comb begin
		out = '0;
		hit = 1'b0;
		for (int i = fetch_pkg::LANES - 1; i >= 0; i--) begin
			if (sel[i]) begin
				out = data[i];
				hit = 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- fetch_pkg.sv
`default_nettype none

package fetch_pkg;

	//////////////////////////////////////////////////
	// Fetch geometry

	localparam int LANES = 5;

	// Bytes per instruction and per full fetch block
	localparam isa_pkg::word_t INSTR_BYTES = 32'd4;
	localparam isa_pkg::word_t BLOCK_BYTES = LANES * INSTR_BYTES;

	// First fetch address after reset
	localparam isa_pkg::word_t RESET_PC = 32'h8000_0000;

	// Return stack size and its occupancy counter
	localparam int RAS_DEPTH = 4;
	localparam int RAS_CNT_W = $clog2(RAS_DEPTH + 1);

	typedef logic [RAS_CNT_W-1:0] ras_cnt_t;

	//////////////////////////////////////////////////
	// Per-lane structs

	// Decoded control for one fetch lane
	typedef struct packed {
		logic           jump;
		logic           jalr;
		logic           link_push;
		logic           link_pop;
		isa_pkg::word_t imm;
	} lane_ctl_t;

	// Addresses handed out for one lane
	typedef struct packed {
		isa_pkg::word_t inst_addr;
		isa_pkg::word_t current_pc;
		isa_pkg::word_t pc_save;
	} lane_addr_t;

	typedef lane_ctl_t [LANES-1:0] ctl_bundle_t;
	typedef lane_addr_t [LANES-1:0] addr_bundle_t;
	typedef isa_pkg::word_t [LANES-1:0] instr_bundle_t;

endpackage

`default_nettype wire

//--- isa_pkg.sv
`default_nettype none

package isa_pkg;

	// Base integer register width
	localparam int XLEN = 32;

	// One instruction word or one byte address
	typedef logic [XLEN-1:0] word_t;

	// Instruction fields
	typedef logic [6:0] opcode_t;
	typedef logic [4:0] reg_t;

	//////////////////////////////////////////////////
	// Major opcodes seen by the fetch pre-decoder

	localparam opcode_t OP_JAL   = 7'b1101111;
	localparam opcode_t OP_JALR  = 7'b1100111;
	localparam opcode_t OP_AUIPC = 7'b0010111;

	//////////////////////////////////////////////////
	// Link registers for return-address hints

	// x1, the usual return address
	localparam reg_t LINK_RA = 5'd1;
	// x5, the alternate link register
	localparam reg_t LINK_ALT = 5'd5;

endpackage

`default_nettype wire
